//--- logic/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// byte address width seen on the AXI4-Lite side
`define CACHE_ADDR_WIDTH 32

// number of sets, 6 index bits
`define CACHE_NUM_SETS 64

// associativity
// the way select and allocation logic is written for exactly 2 ways
`define CACHE_NUM_WAYS 2

// one block per line, same width as the AXI data bus
// gives 3 offset bits and 8 strobe bits
`define CACHE_BLOCK_BITS 64

// reset value of the replacement LFSR, must be nonzero
`define CACHE_LFSR_SEED 8'h01

`endif

//--- logic/cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

    // derived field widths
    localparam int set_bits    = $clog2(`CACHE_NUM_SETS);
    localparam int offset_bits = $clog2(`CACHE_BLOCK_BITS / 8);
    localparam int tag_bits    = `CACHE_ADDR_WIDTH - set_bits - offset_bits;
    localparam int strb_bits   = `CACHE_BLOCK_BITS / 8;

    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [set_bits-1:0] set_idx_t;

    // byte address split, msb first
    typedef struct packed {
        tag_t                   tag;
        set_idx_t               set;
        logic [offset_bits-1:0] offset;
    } addr_fields_t;

    // one way of the tag array
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    typedef logic [`CACHE_BLOCK_BITS-1:0] block_t;

    // one bit per way, one-hot or zero
    typedef logic [`CACHE_NUM_WAYS-1:0] way_mask_t;

    // master to slave
    typedef struct packed {
        logic [`CACHE_ADDR_WIDTH-1:0] awaddr;
        logic                         awvalid;
        block_t                       wdata;
        logic [strb_bits-1:0]         wstrb;
        logic                         wvalid;
        logic                         bready;
        logic [`CACHE_ADDR_WIDTH-1:0] araddr;
        logic                         arvalid;
        logic                         rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic [1:0] bresp;
        logic       bvalid;
        logic       arready;
        block_t     rdata;
        logic [1:0] rresp;
        logic       rvalid;
    } axil_rsp_t;

    // result of tag compare, from way select to the controller
    typedef struct packed {
        logic      hit;
        block_t    data;
        way_mask_t alloc;
    } lookup_t;

    // AXI response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

//--- logic/sram_1rw.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module sram_1rw #(
    parameter type entry_t = logic [7:0],
    parameter int  depth   = 64
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              en,
    input  logic                              we,
    input  logic [$clog2(depth)-1:0]          addr,
    input  cache_pkg::way_mask_t              wmask,
    input  entry_t [`CACHE_NUM_WAYS-1:0]      wdata,
    output entry_t [`CACHE_NUM_WAYS-1:0]      rdata
);

    // one row holds every way of a set
    entry_t [`CACHE_NUM_WAYS-1:0] mem [depth];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // clear all rows, tag valid bits come up zero
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else if (en) begin
            if (we) begin
                // only the masked ways of the row change
                for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
                    if (wmask[w]) begin
                        mem[addr][w] <= wdata[w];
                    end
                end
            end else begin
                // registered read, valid the next cycle
                rdata <= mem[addr];
            end
        end
    end

    // note: rdata holds through a write cycle, the controller
    // still needs the old row for the byte merge

endmodule

//--- logic/way_select.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module way_select (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  cache_pkg::tag_t                            req_tag,
    input  cache_pkg::tag_entry_t [`CACHE_NUM_WAYS-1:0] tags,
    input  cache_pkg::block_t [`CACHE_NUM_WAYS-1:0]     blocks,
    input  logic                                       evict_step,
    output cache_pkg::lookup_t                         lookup
);

    // galois taps for x^8+x^6+x^5+x^4+1, right shifting form
    localparam logic [7:0] lfsr_taps = 8'hb8;

    cache_pkg::way_mask_t valid;
    cache_pkg::way_mask_t match;
    cache_pkg::way_mask_t alloc;
    cache_pkg::block_t    sel_data;
    logic                 evict;
    logic [7:0]           lfsr;

    // tag compare, qualified by the valid bit
    always_comb begin
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
            valid[w] = tags[w].valid;
            match[w] = tags[w].valid && (tags[w].tag == req_tag);
        end
    end

    // one-hot data mux, all zero on a miss
    always_comb begin
        sel_data = '0;
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
            if (match[w]) begin
                sel_data = sel_data | blocks[w];
            end
        end
    end

    // allocation mask
    always_comb begin
        if (|match) begin
            // overwrite the matching way
            // both matching cannot happen, way 0 wins just in case
            alloc = match[0] ? 2'b01 : 2'b10;
        end else if (valid == 2'b11) begin
            // set full, lfsr picks the victim
            alloc = lfsr[0] ? 2'b10 : 2'b01;
        end else if (valid[0]) begin
            // fill the empty way 1
            alloc = 2'b10;
        end else begin
            // way 1 only valid, or both empty
            alloc = 2'b01;
        end
    end

    // eviction means a full set and no hit
    assign evict = !(|match) && (&valid);

    // lfsr steps only on a committed write that replaces a line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= `CACHE_LFSR_SEED;
        end else if (evict_step && evict) begin
            lfsr <= {1'b0, lfsr[7:1]} ^ (lfsr[0] ? lfsr_taps : 8'h00);
        end
    end

    always_comb begin
        lookup.hit   = |match;
        lookup.data  = sel_data;
        lookup.alloc = alloc;
    end

endmodule

//--- logic/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_ctrl (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  cache_pkg::axil_req_t                   req,
    output cache_pkg::axil_rsp_t                   rsp,
    input  cache_pkg::lookup_t                     lookup,
    input  cache_pkg::block_t [`CACHE_NUM_WAYS-1:0] old_blocks,
    output logic                                   arr_en,
    output logic                                   arr_we,
    output cache_pkg::set_idx_t                    arr_addr,
    output cache_pkg::way_mask_t                   arr_wmask,
    output cache_pkg::tag_entry_t                  tag_wdata,
    output cache_pkg::block_t                      data_wdata,
    output cache_pkg::tag_t                        req_tag,
    output logic                                   evict_step
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RD_LOOKUP,
        ST_RD_RESP,
        ST_WR_LOOKUP,
        ST_WR_RESP
    } state_t;

    state_t state;
    state_t state_nxt;

    cache_pkg::addr_fields_t             ar_fields;
    cache_pkg::addr_fields_t             aw_fields;
    logic                                rd_accept;
    logic                                wr_accept;

    // held request and write payload
    cache_pkg::addr_fields_t             addr_q;
    cache_pkg::block_t                   wdata_q;
    logic [cache_pkg::strb_bits-1:0]     wstrb_q;

    // registered read response
    cache_pkg::block_t                   rdata_q;
    logic [1:0]                          rresp_q;

    // old block of the allocated way, for the merge
    cache_pkg::block_t                   old_block;

    assign ar_fields = req.araddr;
    assign aw_fields = req.awaddr;

    // reads win, a write needs aw and w together
    assign rd_accept = (state == ST_IDLE) && req.arvalid;
    assign wr_accept = (state == ST_IDLE) && !req.arvalid && req.awvalid && req.wvalid;

    // state register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (rd_accept) begin
                    state_nxt = ST_RD_LOOKUP;
                end else if (wr_accept) begin
                    state_nxt = ST_WR_LOOKUP;
                end
            end
            ST_RD_LOOKUP: state_nxt = ST_RD_RESP;
            ST_RD_RESP: begin
                if (req.rready) begin
                    state_nxt = ST_IDLE;
                end
            end
            // array write happens in this cycle
            ST_WR_LOOKUP: state_nxt = ST_WR_RESP;
            ST_WR_RESP: begin
                if (req.bready) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    // capture the accepted request
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            addr_q <= ar_fields;
        end else if (wr_accept) begin
            addr_q  <= aw_fields;
            wdata_q <= req.wdata;
            wstrb_q <= req.wstrb;
        end
    end

    // read lookup result, data forced to zero on a miss
    always_ff @(posedge clk) begin
        if (state == ST_RD_LOOKUP) begin
            rdata_q <= lookup.hit ? lookup.data : '0;
            rresp_q <= lookup.hit ? cache_pkg::resp_okay : cache_pkg::resp_slverr;
        end
    end

    // pick the old block of the way about to be written
    always_comb begin
        old_block = '0;
        for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
            if (lookup.alloc[w]) begin
                old_block = old_block | old_blocks[w];
            end
        end
    end

    // byte merge, strobed lanes from wdata and the rest kept
    always_comb begin
        for (int b = 0; b < cache_pkg::strb_bits; b++) begin
            data_wdata[8*b +: 8] = wstrb_q[b] ? wdata_q[8*b +: 8] : old_block[8*b +: 8];
        end
    end

    // new line is always valid with the held tag
    always_comb begin
        tag_wdata.valid = 1'b1;
        tag_wdata.tag   = addr_q.tag;
    end

    assign req_tag = addr_q.tag;

    // array port
    // read in the accept cycle, write in the write lookup cycle
    assign arr_en     = rd_accept || wr_accept || (state == ST_WR_LOOKUP);
    assign arr_we     = (state == ST_WR_LOOKUP);
    assign arr_wmask  = arr_we ? lookup.alloc : '0;
    assign arr_addr   = (state != ST_IDLE) ? addr_q.set :
                        (req.arvalid ? ar_fields.set : aw_fields.set);
    assign evict_step = (state == ST_WR_LOOKUP);

    // AXI4-Lite response side
    always_comb begin
        rsp         = '0;
        rsp.arready = (state == ST_IDLE);
        rsp.awready = wr_accept;
        rsp.wready  = wr_accept;
        rsp.rvalid  = (state == ST_RD_RESP);
        rsp.rdata   = rdata_q;
        rsp.rresp   = rresp_q;
        rsp.bvalid  = (state == ST_WR_RESP);
        rsp.bresp   = cache_pkg::resp_okay;
    end

endmodule

//--- logic/cache_top.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cache_pkg::axil_req_t req,
    output cache_pkg::axil_rsp_t rsp
);

    // shared array port from the controller
    logic                                        arr_en;
    logic                                        arr_we;
    cache_pkg::set_idx_t                         arr_addr;
    cache_pkg::way_mask_t                        arr_wmask;
    cache_pkg::tag_entry_t                       tag_wdata;
    cache_pkg::block_t                           data_wdata;

    // array read rows, one entry per way
    cache_pkg::tag_entry_t [`CACHE_NUM_WAYS-1:0] tag_rdata;
    cache_pkg::block_t [`CACHE_NUM_WAYS-1:0]     data_rdata;

    // lookup path
    cache_pkg::tag_t                             req_tag;
    cache_pkg::lookup_t                          lookup;
    logic                                        evict_step;

    cache_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .rsp        (rsp),
        .lookup     (lookup),
        .old_blocks (data_rdata),
        .arr_en     (arr_en),
        .arr_we     (arr_we),
        .arr_addr   (arr_addr),
        .arr_wmask  (arr_wmask),
        .tag_wdata  (tag_wdata),
        .data_wdata (data_wdata),
        .req_tag    (req_tag),
        .evict_step (evict_step)
    );

    // tag array, the same entry offered to every way
    sram_1rw #(
        .entry_t (cache_pkg::tag_entry_t),
        .depth   (`CACHE_NUM_SETS)
    ) tag_arr (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (arr_en),
        .we    (arr_we),
        .addr  (arr_addr),
        .wmask (arr_wmask),
        .wdata ({`CACHE_NUM_WAYS{tag_wdata}}),
        .rdata (tag_rdata)
    );

    // data array, merged block offered to every way
    sram_1rw #(
        .entry_t (cache_pkg::block_t),
        .depth   (`CACHE_NUM_SETS)
    ) data_arr (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (arr_en),
        .we    (arr_we),
        .addr  (arr_addr),
        .wmask (arr_wmask),
        .wdata ({`CACHE_NUM_WAYS{data_wdata}}),
        .rdata (data_rdata)
    );

    way_select u_way_select (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_tag    (req_tag),
        .tags       (tag_rdata),
        .blocks     (data_rdata),
        .evict_step (evict_step),
        .lookup     (lookup)
    );

endmodule

//--- verif/cache_assertions.sv
`timescale 1ns/1ps

module cache_assertions (
    input logic                 clk,
    input logic                 rst_n,
    input cache_pkg::axil_req_t req,
    input cache_pkg::axil_rsp_t rsp,
    input logic                 arr_we,
    input cache_pkg::way_mask_t arr_wmask
);

    // sticky flag, read by the testbench
    logic failed = 1'b0;

    // read response and its payload hold until rready
    assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.rvalid && !req.rready) |=> (rsp.rvalid && $stable(rsp.rdata) && $stable(rsp.rresp)))
    else begin
        $error("rvalid or read payload changed before rready");
        failed = 1'b1;
    end

    // write response holds until bready
    assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.bvalid && !req.bready) |=> rsp.bvalid)
    else begin
        $error("bvalid dropped before bready");
        failed = 1'b1;
    end

    // nothing accepted while a response is pending
    assert property (@(posedge clk) disable iff (!rst_n)
        (rsp.rvalid || rsp.bvalid) |-> (!rsp.arready && !rsp.awready && !rsp.wready))
    else begin
        $error("ready high while a response is pending");
        failed = 1'b1;
    end

    // an array write touches exactly one way
    assert property (@(posedge clk) disable iff (!rst_n)
        arr_we |-> $onehot(arr_wmask))
    else begin
        $error("array write mask not one-hot");
        failed = 1'b1;
    end

    // responses idle once reset has been seen
    assert property (@(posedge clk) !rst_n |=> (!rsp.rvalid && !rsp.bvalid))
    else begin
        $error("response valid right after reset");
        failed = 1'b1;
    end

endmodule

//--- verif/tb_cache.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module tb_cache;

    localparam int max_cycles = 600 * 20;
    localparam int num_random = 560;

    logic                 clk;
    logic                 rst_n;
    cache_pkg::axil_req_t req;
    cache_pkg::axil_rsp_t rsp;
    int                   cycles = 0;

    // model of the cache, per set and way
    logic                 m_valid [64][2];
    logic [22:0]          m_tag   [64][2];
    logic [63:0]          m_block [64][2];
    logic [7:0]           m_lfsr;

    cache_top DUT (.clk(clk), .rst_n(rst_n), .req(req), .rsp(rsp));

    bind cache_ctrl cache_assertions u_assertions (
        .clk(clk), .rst_n(rst_n), .req(req), .rsp(rsp), .arr_we(arr_we), .arr_wmask(arr_wmask)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit and assertion watch
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (DUT.u_ctrl.u_assertions.failed) begin
            $display("an assertion on the controller failed");
            $display("*** FAILED ***");
            $fatal(1, "assertion failure");
        end else if (cycles >= max_cycles) begin
            $display("timeout, the run did not finish within %0d cycles", max_cycles);
            $display("*** FAILED ***");
            $fatal(1, "timeout");
        end
    end

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        if (got !== exp) begin
            $display("Fail %0t: %s, got %h expected %h", $time, msg, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "mismatch");
        end
    endtask

    // 4 sets and 6 tags, offset is don't care
    function automatic logic [31:0] pick_addr(input int t, input int s);
        logic [22:0] tag;
        tag = 23'h1000 + 23'(t * 13);
        return {tag, 6'(s * 21), 3'($urandom_range(0, 7))};
    endfunction

    task automatic model_read(input logic [31:0] a, output logic [63:0] d, output logic [1:0] r);
        d = '0;
        r = 2'b10;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[a[8:3]][w] && m_tag[a[8:3]][w] == a[31:9]) begin
                d = m_block[a[8:3]][w];
                r = 2'b00;
            end
        end
    endtask

    // hit way, else empty way, else lfsr victim
    task automatic model_write(input logic [31:0] a, input logic [63:0] d, input logic [7:0] s);
        int idx;
        int way;
        idx = a[8:3];
        if (m_valid[idx][0] && m_tag[idx][0] == a[31:9]) way = 0;
        else if (m_valid[idx][1] && m_tag[idx][1] == a[31:9]) way = 1;
        else if (m_valid[idx][0] && m_valid[idx][1]) begin
            way = m_lfsr[0];
            // galois step for x^8+x^6+x^5+x^4+1
            m_lfsr = {1'b0, m_lfsr[7:1]} ^ (m_lfsr[0] ? 8'hb8 : 8'h00);
        end else if (m_valid[idx][0]) way = 1;
        else way = 0;
        for (int b = 0; b < 8; b++) begin
            if (s[b]) m_block[idx][way][8*b +: 8] = d[8*b +: 8];
        end
        m_valid[idx][way] = 1'b1;
        m_tag[idx][way] = a[31:9];
    endtask

    task automatic read_accept();
        @(negedge clk);
        while (!rsp.arready) @(negedge clk);
        // read wins over a write offered alongside
        check(rsp.awready, 0, "write accepted together with a read");
        @(posedge clk);
        #1 req.arvalid = 1'b0;
    endtask

    task automatic read_finish(input logic [31:0] a);
        logic [63:0] exp_data;
        logic [1:0]  exp_resp;
        logic [63:0] first_data;
        model_read(a, exp_data, exp_resp);
        @(negedge clk);
        while (!rsp.rvalid) @(negedge clk);
        first_data = rsp.rdata;
        // master stalls for a few cycles
        repeat ($urandom_range(0, 3)) begin
            @(negedge clk);
            check(rsp.rvalid, 1, "rvalid dropped before rready");
            check(rsp.rdata, first_data, "rdata changed under back-pressure");
        end
        @(posedge clk);
        #1 req.rready = 1'b1;
        @(negedge clk);
        check(rsp.rvalid, 1, "rvalid low with rready high");
        check(rsp.rresp, exp_resp, $sformatf("rresp for address %h", a));
        check(rsp.rdata, exp_data, $sformatf("rdata for address %h", a));
        @(posedge clk);
        #1 req.rready = 1'b0;
    endtask

    task automatic write_issue(input logic [31:0] a, input logic [63:0] d, input logic [7:0] s);
        req.awaddr = a;
        req.awvalid = 1'b1;
        req.wdata = d;
        req.wstrb = s;
        req.wvalid = 1'b1;
    endtask

    task automatic write_accept();
        @(negedge clk);
        while (!rsp.awready) @(negedge clk);
        check(rsp.wready, 1, "wready not raised with awready");
        @(posedge clk);
        #1 req.awvalid = 1'b0;
        req.wvalid = 1'b0;
    endtask

    task automatic write_finish(input logic [31:0] a, input logic [63:0] d, input logic [7:0] s);
        model_write(a, d, s);
        @(negedge clk);
        while (!rsp.bvalid) @(negedge clk);
        repeat ($urandom_range(0, 3)) begin
            @(negedge clk);
            check(rsp.bvalid, 1, "bvalid dropped before bready");
        end
        @(posedge clk);
        #1 req.bready = 1'b1;
        @(negedge clk);
        check(rsp.bvalid, 1, "bvalid low with bready high");
        check(rsp.bresp, 2'b00, "bresp is not OKAY");
        @(posedge clk);
        #1 req.bready = 1'b0;
    endtask

    task automatic do_read(input logic [31:0] a);
        req.araddr = a;
        req.arvalid = 1'b1;
        read_accept();
        read_finish(a);
    endtask

    task automatic do_write(input logic [31:0] a, input logic [63:0] d, input logic [7:0] s);
        write_issue(a, d, s);
        write_accept();
        write_finish(a, d, s);
    endtask

    // both offered in one cycle, the read goes first
    task automatic rw_pair(input logic [31:0] ra, input logic [31:0] wa,
                           input logic [63:0] d, input logic [7:0] s);
        req.araddr = ra;
        req.arvalid = 1'b1;
        write_issue(wa, d, s);
        read_accept();
        read_finish(ra);
        write_accept();
        write_finish(wa, d, s);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] d;
        logic [7:0]  s;
        void'($urandom(32'hb758_e803));
        req = '0;
        rst_n = 1'b0;
        m_lfsr = `CACHE_LFSR_SEED;
        for (int i = 0; i < 64; i++) begin
            for (int w = 0; w < 2; w++) begin
                m_valid[i][w] = 1'b0;
                m_tag[i][w] = '0;
                m_block[i][w] = '0;
            end
        end
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check(rsp.arready, 1, "arready low after reset");
        @(posedge clk);
        #1;
        // untouched line misses
        a = pick_addr(0, 0);
        do_read(a);
        // full write, read back, then partial write into the hit line
        do_write(a, {$urandom, $urandom}, 8'hff);
        do_read(a);
        do_write(a, {$urandom, $urandom}, 8'h5a);
        do_read(a);
        // fill way 1, third tag evicts the lfsr victim
        do_write(pick_addr(1, 0), {$urandom, $urandom}, 8'hff);
        do_write(pick_addr(2, 0), {$urandom, $urandom}, 8'hff);
        for (int t = 0; t < 3; t++) do_read(pick_addr(t, 0));
        rw_pair(pick_addr(2, 0), pick_addr(3, 0), {$urandom, $urandom}, 8'hf0);
        for (int n = 0; n < num_random; n++) begin
            a = pick_addr($urandom_range(0, 5), $urandom_range(0, 3));
            b = pick_addr($urandom_range(0, 5), $urandom_range(0, 3));
            d = {$urandom, $urandom};
            s = ($urandom_range(0, 3) == 0) ? 8'hff : 8'($urandom);
            case ($urandom_range(0, 4))
                0, 1: do_read(a);
                2, 3: do_write(a, d, s);
                default: rw_pair(a, b, d, s);
            endcase
        end
        if (DUT.u_ctrl.u_assertions.failed) begin
            $display("*** FAILED ***");
            $fatal(1, "assertion failure");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

//--- tb.f
+incdir+logic
logic/cache_pkg.sv
logic/sram_1rw.sv
logic/way_select.sv
logic/cache_ctrl.sv
logic/cache_top.sv
verif/cache_assertions.sv
verif/tb_cache.sv

//--- Bender.yml
package:
  name: cache_2way
export_include_dirs:
  - logic
sources:
  - logic/cache_pkg.sv
  - logic/sram_1rw.sv
  - logic/way_select.sv
  - logic/cache_ctrl.sv
  - logic/cache_top.sv
  - target: test
    files:
      - verif/cache_assertions.sv
      - verif/tb_cache.sv
